/* bench/thumb_testdata.hex */
// columns: instruction (4 digits), expected opt_o (8 digits), expected NZCV (1 digit)
// one step per line, checked two edges after the instruction is driven
207F0000007F0
2181000000810
1842000001000
1E53000000FF2
1A1C000000802
1924000001000
1AA5000000006
2880FFFFFFFF8
4210000000004
42C8000001000
46800000007F0
26C1000000C10
0636C10000008
0E77000000602
0035C1000000A
1135FC1000008
2320000000200
41DDFC100000A
413DFFFFFFFFA
40D6C1000000A
409D000000004
41C682000001A
4145000000800
419C000000DF2
4247FFFFFF818
43DBFFFFFFDF8
19B2040000023
4032000000007
433282000001B
407A7DFFFF803
438A7DFFFF003
434A7DFF7F003
4480000000FE3
46C5000000FE3
A9100000013E3
A001000000043
4588FFFFFFC08
6800FFFFFFC08
2500000000004
D0FE000000004
4770000000004
1DE6000000E60

/* project.f */
hdl/cpu_pkg.sv
hdl/thumb_decoder.sv
hdl/operand_stage.sv
hdl/register_file.sv
hdl/barrel_shifter.sv
hdl/alu_execute.sv
hdl/result_stage.sv
hdl/thumb_core.sv
bench/tb_thumb_core.sv

/* Bender.yml */
package:
  name: thumb_core

sources:
  - hdl/cpu_pkg.sv
  - hdl/thumb_decoder.sv
  - hdl/operand_stage.sv
  - hdl/register_file.sv
  - hdl/barrel_shifter.sv
  - hdl/alu_execute.sv
  - hdl/result_stage.sv
  - hdl/thumb_core.sv
  - target: test
    files:
      - bench/tb_thumb_core.sv

/* bench/tb_thumb_core.sv */
// testbench for thumb_core that replays the steps of the hex data file and checks each result
`default_nettype none

module tb_thumb_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_STEPS    = 42;
    // a result shows up two edges after its instruction is driven
    localparam int LATENCY      = 2;
    localparam int VEC_BITS     = 16 + 32 + 4;
    localparam int WATCHDOG_NS  = (NUM_STEPS + 10) * CLK_PERIOD;

    // dropped svc encoding driven when no step is due
    localparam logic [15:0] FILL_CMD = 16'hdf00;

    logic        sck;
    logic        arst_n;
    logic [15:0] cmd;
    logic [31:0] opt;
    logic [31:0] sta;

    // instruction, expected opt_o, expected nzcv
    logic [VEC_BITS-1:0] vectors [NUM_STEPS];

    int pass_count;
    int fail_count;

    thumb_core u_thumb_core (
        .sck      (sck),
        .arst_n_i (arst_n),
        .cmd_i    (cmd),
        .opt_o    (opt),
        .sta_o    (sta)
    );

    initial begin
        sck = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) sck = ~sck;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // outputs right after reset must read as zero
    task automatic check_reset_state();
        if ((opt !== 32'h0) || (sta !== 32'h0)) begin
            $display("reset: outputs not cleared, opt_o %08h, sta_o %08h", opt, sta);
            fail_count++;
        end else begin
            $display("reset: ok");
            pass_count++;
        end
    endtask

    task automatic compare_step(input int idx);
        logic [15:0] instr;
        logic [31:0] exp_opt;
        logic [31:0] exp_sta;
        logic        ok;
        instr   = vectors[idx][VEC_BITS-1 -: 16];
        exp_opt = vectors[idx][35:4];
        // nzcv sits in the top nibble above 28 zero bits
        exp_sta = {vectors[idx][3:0], 28'h0};
        ok      = 1'b1;
        if (opt !== exp_opt) begin
            $display("MISMATCH step %0d opt_o: expected %08h, actual %08h", idx, exp_opt, opt);
            ok = 1'b0;
        end
        if (sta !== exp_sta) begin
            $display("MISMATCH step %0d sta_o: expected %08h, actual %08h", idx, exp_sta, sta);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("step %0d cmd %04h: ok", idx, instr);
        end else begin
            fail_count++;
            $display("step %0d cmd %04h: failed", idx, instr);
        end
    endtask

    initial begin
        pass_count = 0;
        fail_count = 0;
        arst_n     = 1'b0;
        cmd        = FILL_CMD;
        $readmemh("bench/thumb_testdata.hex", vectors);
        if ($isunknown(vectors[NUM_STEPS-1])) begin
            $display("data file bench/thumb_testdata.hex is missing or holds too few steps");
            fail_count++;
        end

        repeat (RESET_CYCLES + 1) @(posedge sck);
        arst_n <= 1'b1;
        @(negedge sck);
        check_reset_state();

        // drive one step per edge and check the step driven two edges earlier
        for (int j = 0; j < NUM_STEPS + LATENCY; j++) begin
            @(posedge sck);
            if (j < NUM_STEPS) begin
                cmd <= vectors[j][VEC_BITS-1 -: 16];
            end else begin
                cmd <= FILL_CMD;
            end
            @(negedge sck);
            if (j >= LATENCY) begin
                compare_step(j - LATENCY);
            end
        end

        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/thumb_core.sv */
// top level of the two-stage thumb datapath, one instruction in on cmd_i per sck edge
`default_nettype none

module thumb_core (
    input  wire logic                          sck,
    input  wire logic                          arst_n_i,
    input  wire logic [15:0]                   cmd_i,
    output logic [cpu_pkg::SYS_BITS-1:0]       opt_o,
    output logic [cpu_pkg::SYS_BITS-1:0]       sta_o
);

    // decode outputs
    logic [cpu_pkg::REG_ADDR_BITS-1:0] dec_rn_addr;
    logic [cpu_pkg::REG_ADDR_BITS-1:0] dec_rm_addr;
    logic [cpu_pkg::REG_ADDR_BITS-1:0] dec_rd_addr;
    logic [cpu_pkg::SYS_BITS-1:0]      dec_imm;
    logic                              dec_use_imm;
    logic                              dec_zero_n;
    logic                              dec_invert_m;
    logic                              dec_rd_we;
    logic                              dec_set_flags;
    cpu_pkg::alu_op_e                  dec_op;
    cpu_pkg::shift_kind_e              dec_shift_kind;
    cpu_pkg::bitwise_kind_e            dec_bitwise_kind;
    cpu_pkg::cin_sel_e                 dec_cin_sel;

    logic [cpu_pkg::SYS_BITS-1:0]      rn_data;
    logic [cpu_pkg::SYS_BITS-1:0]      rm_data;

    // issue register
    logic [cpu_pkg::SYS_BITS-1:0]      iss_n;
    logic [cpu_pkg::SYS_BITS-1:0]      iss_m;
    logic                              iss_valid;
    logic [cpu_pkg::REG_ADDR_BITS-1:0] iss_rd_addr;
    logic                              iss_rd_we;
    logic                              iss_set_flags;
    cpu_pkg::alu_op_e                  iss_op;
    cpu_pkg::shift_kind_e              iss_shift_kind;
    cpu_pkg::bitwise_kind_e            iss_bitwise_kind;
    cpu_pkg::cin_sel_e                 iss_cin_sel;

    logic [cpu_pkg::SYS_BITS-1:0]      ex_result;
    logic                              ex_carry;
    logic                              ex_overflow;
    logic                              cf;
    logic                              vf;

    thumb_decoder u_thumb_decoder (
        .cmd_i          (cmd_i),
        .rn_addr_o      (dec_rn_addr),
        .rm_addr_o      (dec_rm_addr),
        .rd_addr_o      (dec_rd_addr),
        .imm_o          (dec_imm),
        .use_imm_o      (dec_use_imm),
        .zero_n_o       (dec_zero_n),
        .invert_m_o     (dec_invert_m),
        .rd_we_o        (dec_rd_we),
        .set_flags_o    (dec_set_flags),
        .op_o           (dec_op),
        .shift_kind_o   (dec_shift_kind),
        .bitwise_kind_o (dec_bitwise_kind),
        .cin_sel_o      (dec_cin_sel)
    );

    operand_stage u_operand_stage (
        .sck            (sck),
        .arst_n_i       (arst_n_i),
        .rd_addr_i      (dec_rd_addr),
        .imm_i          (dec_imm),
        .use_imm_i      (dec_use_imm),
        .zero_n_i       (dec_zero_n),
        .invert_m_i     (dec_invert_m),
        .rd_we_i        (dec_rd_we),
        .set_flags_i    (dec_set_flags),
        .op_i           (dec_op),
        .shift_kind_i   (dec_shift_kind),
        .bitwise_kind_i (dec_bitwise_kind),
        .cin_sel_i      (dec_cin_sel),
        .rn_data_i      (rn_data),
        .rm_data_i      (rm_data),
        .n_o            (iss_n),
        .m_o            (iss_m),
        .valid_o        (iss_valid),
        .rd_addr_o      (iss_rd_addr),
        .rd_we_o        (iss_rd_we),
        .set_flags_o    (iss_set_flags),
        .op_o           (iss_op),
        .shift_kind_o   (iss_shift_kind),
        .bitwise_kind_o (iss_bitwise_kind),
        .cin_sel_o      (iss_cin_sel)
    );

    register_file u_register_file (
        .sck       (sck),
        .arst_n_i  (arst_n_i),
        .rn_addr_i (dec_rn_addr),
        .rm_addr_i (dec_rm_addr),
        .rn_data_o (rn_data),
        .rm_data_o (rm_data),
        .wr_en_i   (iss_rd_we),
        .wr_addr_i (iss_rd_addr),
        .wr_data_i (ex_result)
    );

    alu_execute u_alu_execute (
        .n_i            (iss_n),
        .m_i            (iss_m),
        .op_i           (iss_op),
        .shift_kind_i   (iss_shift_kind),
        .bitwise_kind_i (iss_bitwise_kind),
        .cin_sel_i      (iss_cin_sel),
        .cf_i           (cf),
        .vf_i           (vf),
        .result_o       (ex_result),
        .carry_o        (ex_carry),
        .overflow_o     (ex_overflow)
    );

    result_stage u_result_stage (
        .sck         (sck),
        .arst_n_i    (arst_n_i),
        .valid_i     (iss_valid),
        .set_flags_i (iss_set_flags),
        .result_i    (ex_result),
        .carry_i     (ex_carry),
        .overflow_i  (ex_overflow),
        .cf_o        (cf),
        .vf_o        (vf),
        .opt_o       (opt_o),
        .sta_o       (sta_o)
    );

endmodule

`default_nettype wire

/* hdl/result_stage.sv */
// holds the latest result and the NZCV flags and builds the status word
`default_nettype none

module result_stage (
    input  wire logic                          sck,
    input  wire logic                          arst_n_i,
    input  wire logic                          valid_i,
    input  wire logic                          set_flags_i,
    input  wire logic [cpu_pkg::SYS_BITS-1:0]  result_i,
    input  wire logic                          carry_i,
    input  wire logic                          overflow_i,
    output logic                               cf_o,
    output logic                               vf_o,
    output logic [cpu_pkg::SYS_BITS-1:0]       opt_o,
    output logic [cpu_pkg::SYS_BITS-1:0]       sta_o
);

    logic nf;
    logic zf;
    logic cf;
    logic vf;

    always_ff @(posedge sck or negedge arst_n_i) begin
        if (!arst_n_i) begin
            opt_o <= '0;
            nf    <= 1'b0;
            zf    <= 1'b0;
            cf    <= 1'b0;
            vf    <= 1'b0;
        end else if (valid_i) begin
            opt_o <= result_i;
            if (set_flags_i) begin
                nf <= result_i[cpu_pkg::SYS_BITS-1];
                zf <= (result_i == '0);
                cf <= carry_i;
                vf <= overflow_i;
            end
        end
    end

    always_comb begin
        sta_o                 = '0;
        sta_o[cpu_pkg::FLAG_N] = nf;
        sta_o[cpu_pkg::FLAG_Z] = zf;
        sta_o[cpu_pkg::FLAG_C] = cf;
        sta_o[cpu_pkg::FLAG_V] = vf;
    end

    assign cf_o = cf;
    assign vf_o = vf;

    // a valid slot must bring a fully known result
    assert property (@(posedge sck) disable iff (!arst_n_i)
        valid_i |-> !$isunknown({result_i, carry_i, overflow_i}))
        else $error("valid slot carries an unknown result or flag");

endmodule

`default_nettype wire

/* hdl/alu_execute.sv */
// execute stage, picks shift, add, multiply or bitwise result with carry and overflow
`default_nettype none

module alu_execute (
    input  wire logic [cpu_pkg::SYS_BITS-1:0]  n_i,
    input  wire logic [cpu_pkg::SYS_BITS-1:0]  m_i,
    input  wire cpu_pkg::alu_op_e              op_i,
    input  wire cpu_pkg::shift_kind_e          shift_kind_i,
    input  wire cpu_pkg::bitwise_kind_e        bitwise_kind_i,
    input  wire cpu_pkg::cin_sel_e             cin_sel_i,
    input  wire logic                          cf_i,
    input  wire logic                          vf_i,
    output logic [cpu_pkg::SYS_BITS-1:0]       result_o,
    output logic                               carry_o,
    output logic                               overflow_o
);

    localparam int MSB = cpu_pkg::SYS_BITS - 1;

    logic [MSB:0]  sh_result;
    logic          sh_carry;
    logic          cin;
    logic [MSB+1:0] sum;
    logic          add_v;
    logic [MSB:0]  product;
    logic [MSB:0]  bw_result;

    // shift amount comes from the low byte of m
    barrel_shifter u_barrel_shifter (
        .value_i  (n_i),
        .amount_i (m_i[7:0]),
        .kind_i   (shift_kind_i),
        .carry_i  (cf_i),
        .result_o (sh_result),
        .carry_o  (sh_carry)
    );

    // flag carry-in is read here so adc/sbc see the flags written one edge earlier
    always_comb begin
        case (cin_sel_i)
            cpu_pkg::CIN_ONE:  cin = 1'b1;
            cpu_pkg::CIN_FLAG: cin = cf_i;
            default:           cin = 1'b0;
        endcase
    end

    assign sum     = {1'b0, n_i} + {1'b0, m_i} + {{cpu_pkg::SYS_BITS{1'b0}}, cin};
    assign add_v   = (n_i[MSB] == m_i[MSB]) && (sum[MSB] != n_i[MSB]);
    assign product = n_i * m_i;

    always_comb begin
        case (bitwise_kind_i)
            cpu_pkg::BW_ORR: bw_result = n_i | m_i;
            cpu_pkg::BW_XOR: bw_result = n_i ^ m_i;
            default:         bw_result = n_i & m_i;
        endcase
    end

    always_comb begin
        result_o   = '0;
        carry_o    = cf_i;
        overflow_o = vf_i;
        case (op_i)
            cpu_pkg::ALU_SHIFT: begin
                result_o = sh_result;
                carry_o  = sh_carry;
            end
            cpu_pkg::ALU_ADD: begin
                result_o   = sum[MSB:0];
                carry_o    = sum[MSB+1];
                overflow_o = add_v;
            end
            cpu_pkg::ALU_MUL:     result_o = product;
            cpu_pkg::ALU_BITWISE: result_o = bw_result;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/barrel_shifter.sv */
// LSL, LSR, ASR and ROR of one 32-bit value with the shifter carry-out
`default_nettype none

module barrel_shifter (
    input  wire logic [cpu_pkg::SYS_BITS-1:0]  value_i,
    input  wire logic [7:0]                    amount_i,
    input  wire cpu_pkg::shift_kind_e          kind_i,
    input  wire logic                          carry_i,
    output logic [cpu_pkg::SYS_BITS-1:0]       result_o,
    output logic                               carry_o
);

    logic [5:0]                           amt;
    logic                                 fill;
    logic signed [cpu_pkg::SYS_BITS+1:0]  ext;
    logic [cpu_pkg::SYS_BITS+1:0]         shr;
    logic [cpu_pkg::SYS_BITS:0]           shl;
    logic [4:0]                           rot;
    logic [cpu_pkg::SYS_BITS-1:0]         rotated;

    assign amt  = (amount_i >= 8'd32) ? cpu_pkg::SHIFT_SAT : amount_i[5:0];
    assign fill = (kind_i == cpu_pkg::SH_ASR) && value_i[cpu_pkg::SYS_BITS-1];

    // carry rides below the value, so the last bit out lands in bit 0
    assign ext = {fill, value_i, carry_i};
    assign shr = ext >>> amt;
    assign shl = {carry_i, value_i} << amt;

    assign rot     = amount_i[4:0];
    assign rotated = (value_i >> rot) | (value_i << (6'd32 - {1'b0, rot}));

    always_comb begin
        case (kind_i)
            cpu_pkg::SH_LSL: begin
                result_o = shl[cpu_pkg::SYS_BITS-1:0];
                carry_o  = shl[cpu_pkg::SYS_BITS];
            end
            cpu_pkg::SH_LSR, cpu_pkg::SH_ASR: begin
                result_o = shr[cpu_pkg::SYS_BITS:1];
                carry_o  = shr[0];
            end
            default: begin
                result_o = rotated;
                carry_o  = (amount_i == 8'd0) ? carry_i : rotated[cpu_pkg::SYS_BITS-1];
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
// sixteen 32-bit registers, two combinational read ports and one write port with bypass
`default_nettype none

module register_file (
    input  wire logic                                 sck,
    input  wire logic                                 arst_n_i,
    input  wire logic [cpu_pkg::REG_ADDR_BITS-1:0]    rn_addr_i,
    input  wire logic [cpu_pkg::REG_ADDR_BITS-1:0]    rm_addr_i,
    output logic [cpu_pkg::SYS_BITS-1:0]              rn_data_o,
    output logic [cpu_pkg::SYS_BITS-1:0]              rm_data_o,
    input  wire logic                                 wr_en_i,
    input  wire logic [cpu_pkg::REG_ADDR_BITS-1:0]    wr_addr_i,
    input  wire logic [cpu_pkg::SYS_BITS-1:0]         wr_data_i
);

    logic [cpu_pkg::SYS_BITS-1:0] regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge sck or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // the instruction issuing now sees the value retiring at the same edge
    assign rn_data_o = (wr_en_i && (wr_addr_i == rn_addr_i)) ? wr_data_i : regs[rn_addr_i];
    assign rm_data_o = (wr_en_i && (wr_addr_i == rm_addr_i)) ? wr_data_i : regs[rm_addr_i];

    assert property (@(posedge sck) disable iff (!arst_n_i)
        wr_en_i |-> !$isunknown(wr_addr_i))
        else $error("register write with unknown address");

endmodule

`default_nettype wire

/* hdl/operand_stage.sv */
// forms the n and m operands and holds them with the controls in the issue register
`default_nettype none

module operand_stage (
    input  wire logic                                 sck,
    input  wire logic                                 arst_n_i,
    input  wire logic [cpu_pkg::REG_ADDR_BITS-1:0]    rd_addr_i,
    input  wire logic [cpu_pkg::SYS_BITS-1:0]         imm_i,
    input  wire logic                                 use_imm_i,
    input  wire logic                                 zero_n_i,
    input  wire logic                                 invert_m_i,
    input  wire logic                                 rd_we_i,
    input  wire logic                                 set_flags_i,
    input  wire cpu_pkg::alu_op_e                     op_i,
    input  wire cpu_pkg::shift_kind_e                 shift_kind_i,
    input  wire cpu_pkg::bitwise_kind_e               bitwise_kind_i,
    input  wire cpu_pkg::cin_sel_e                    cin_sel_i,
    input  wire logic [cpu_pkg::SYS_BITS-1:0]         rn_data_i,
    input  wire logic [cpu_pkg::SYS_BITS-1:0]         rm_data_i,
    output logic [cpu_pkg::SYS_BITS-1:0]              n_o,
    output logic [cpu_pkg::SYS_BITS-1:0]              m_o,
    output logic                                      valid_o,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0]         rd_addr_o,
    output logic                                      rd_we_o,
    output logic                                      set_flags_o,
    output cpu_pkg::alu_op_e                          op_o,
    output cpu_pkg::shift_kind_e                      shift_kind_o,
    output cpu_pkg::bitwise_kind_e                    bitwise_kind_o,
    output cpu_pkg::cin_sel_e                         cin_sel_o
);

    logic                          valid_d;
    logic [cpu_pkg::SYS_BITS-1:0]  m_sel;

    assign valid_d = (op_i != cpu_pkg::ALU_NONE);
    assign m_sel   = use_imm_i ? imm_i : rm_data_i;

    // m arrives inverted for subtraction and mvn
    always_ff @(posedge sck) begin
        n_o <= zero_n_i ? '0 : rn_data_i;
        m_o <= invert_m_i ? ~m_sel : m_sel;
    end

    always_ff @(posedge sck or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o        <= 1'b0;
            rd_addr_o      <= '0;
            rd_we_o        <= 1'b0;
            set_flags_o    <= 1'b0;
            op_o           <= cpu_pkg::ALU_NONE;
            shift_kind_o   <= cpu_pkg::SH_LSL;
            bitwise_kind_o <= cpu_pkg::BW_AND;
            cin_sel_o      <= cpu_pkg::CIN_ZERO;
        end else begin
            valid_o        <= valid_d;
            rd_addr_o      <= rd_addr_i;
            // write enable already qualified by valid
            rd_we_o        <= rd_we_i && valid_d;
            set_flags_o    <= set_flags_i;
            op_o           <= op_i;
            shift_kind_o   <= shift_kind_i;
            bitwise_kind_o <= bitwise_kind_i;
            cin_sel_o      <= cin_sel_i;
        end
    end

    // decoded writes and flag updates only come with an operation
    assert property (@(posedge sck) disable iff (!arst_n_i)
        (rd_we_i || set_flags_i) |-> (op_i != cpu_pkg::ALU_NONE))
        else $error("decoder requests a write or flag update without an operation");

endmodule

`default_nettype wire

/* hdl/thumb_decoder.sv */
// combinational decode of one 16-bit instruction into register addresses and operand recipe
`default_nettype none

module thumb_decoder (
    input  wire logic [15:0]                          cmd_i,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0]         rn_addr_o,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0]         rm_addr_o,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0]         rd_addr_o,
    output logic [cpu_pkg::SYS_BITS-1:0]              imm_o,
    output logic                                      use_imm_o,
    output logic                                      zero_n_o,
    output logic                                      invert_m_o,
    output logic                                      rd_we_o,
    output logic                                      set_flags_o,
    output cpu_pkg::alu_op_e                          op_o,
    output cpu_pkg::shift_kind_e                      shift_kind_o,
    output cpu_pkg::bitwise_kind_e                    bitwise_kind_o,
    output cpu_pkg::cin_sel_e                         cin_sel_o
);

    always_comb begin
        // low register fields of the common formats
        rn_addr_o      = {1'b0, cmd_i[5:3]};
        rm_addr_o      = {1'b0, cmd_i[8:6]};
        rd_addr_o      = {1'b0, cmd_i[2:0]};
        imm_o          = '0;
        use_imm_o      = 1'b0;
        zero_n_o       = 1'b0;
        invert_m_o     = 1'b0;
        rd_we_o        = 1'b0;
        set_flags_o    = 1'b0;
        op_o           = cpu_pkg::ALU_NONE;
        shift_kind_o   = cpu_pkg::SH_LSL;
        bitwise_kind_o = cpu_pkg::BW_AND;
        cin_sel_o      = cpu_pkg::CIN_ZERO;

        casez (cmd_i[15:10])
            // add/sub with register or imm3, ahead of the shift group it overlaps
            6'b00011?: begin
                op_o        = cpu_pkg::ALU_ADD;
                use_imm_o   = cmd_i[10];
                imm_o[2:0]  = cmd_i[8:6];
                invert_m_o  = cmd_i[9];
                cin_sel_o   = cmd_i[9] ? cpu_pkg::CIN_ONE : cpu_pkg::CIN_ZERO;
                rd_we_o     = 1'b1;
                set_flags_o = 1'b1;
            end
            // shift by imm5, value taken from the n port
            6'b000???: begin
                op_o         = cpu_pkg::ALU_SHIFT;
                shift_kind_o = cpu_pkg::shift_kind_e'(cmd_i[12:11]);
                use_imm_o    = 1'b1;
                imm_o[4:0]   = cmd_i[10:6];
                rd_we_o      = 1'b1;
                set_flags_o  = 1'b1;
            end
            // mov/cmp/add/sub with imm8
            6'b001???: begin
                op_o        = cpu_pkg::ALU_ADD;
                rn_addr_o   = {1'b0, cmd_i[10:8]};
                rd_addr_o   = {1'b0, cmd_i[10:8]};
                use_imm_o   = 1'b1;
                imm_o[7:0]  = cmd_i[7:0];
                zero_n_o    = (cmd_i[12:11] == 2'b00);
                invert_m_o  = cmd_i[11];
                cin_sel_o   = cmd_i[11] ? cpu_pkg::CIN_ONE : cpu_pkg::CIN_ZERO;
                rd_we_o     = (cmd_i[12:11] != 2'b01);
                set_flags_o = 1'b1;
            end
            // register data processing, rd doubles as first operand
            6'b010000: begin
                rm_addr_o   = {1'b0, cmd_i[5:3]};
                rn_addr_o   = {1'b0, cmd_i[2:0]};
                rd_we_o     = 1'b1;
                set_flags_o = 1'b1;
                op_o        = cpu_pkg::ALU_ADD;
                case (cmd_i[9:6])
                    4'b0000: op_o = cpu_pkg::ALU_BITWISE;
                    4'b0001: begin
                        op_o           = cpu_pkg::ALU_BITWISE;
                        bitwise_kind_o = cpu_pkg::BW_XOR;
                    end
                    4'b0010, 4'b0011, 4'b0100: begin
                        op_o         = cpu_pkg::ALU_SHIFT;
                        shift_kind_o = cpu_pkg::shift_kind_e'(cmd_i[7:6] - 2'd2);
                    end
                    4'b0101: cin_sel_o = cpu_pkg::CIN_FLAG;
                    4'b0110: begin
                        invert_m_o = 1'b1;
                        cin_sel_o  = cpu_pkg::CIN_FLAG;
                    end
                    4'b0111: begin
                        op_o         = cpu_pkg::ALU_SHIFT;
                        shift_kind_o = cpu_pkg::SH_ROR;
                    end
                    4'b1000: begin
                        op_o    = cpu_pkg::ALU_BITWISE;
                        rd_we_o = 1'b0;
                    end
                    4'b1001: begin
                        zero_n_o   = 1'b1;
                        invert_m_o = 1'b1;
                        cin_sel_o  = cpu_pkg::CIN_ONE;
                    end
                    4'b1010: begin
                        invert_m_o = 1'b1;
                        cin_sel_o  = cpu_pkg::CIN_ONE;
                        rd_we_o    = 1'b0;
                    end
                    4'b1011: rd_we_o = 1'b0;
                    4'b1100: begin
                        op_o           = cpu_pkg::ALU_BITWISE;
                        bitwise_kind_o = cpu_pkg::BW_ORR;
                    end
                    4'b1101: op_o = cpu_pkg::ALU_MUL;
                    4'b1110: begin
                        op_o       = cpu_pkg::ALU_BITWISE;
                        invert_m_o = 1'b1;
                    end
                    default: begin
                        // mvn as 0 + ~m
                        zero_n_o   = 1'b1;
                        invert_m_o = 1'b1;
                    end
                endcase
            end
            // high register add/cmp/mov, bx encodings stay a no-op
            6'b010001: begin
                rn_addr_o = {cmd_i[7], cmd_i[2:0]};
                rd_addr_o = {cmd_i[7], cmd_i[2:0]};
                rm_addr_o = cmd_i[6:3];
                if (cmd_i[9:8] != 2'b11) begin
                    op_o        = cpu_pkg::ALU_ADD;
                    zero_n_o    = (cmd_i[9:8] == 2'b10);
                    invert_m_o  = (cmd_i[9:8] == 2'b01);
                    cin_sel_o   = cmd_i[8] ? cpu_pkg::CIN_ONE : cpu_pkg::CIN_ZERO;
                    rd_we_o     = (cmd_i[9:8] != 2'b01);
                    set_flags_o = (cmd_i[9:8] == 2'b01) &&
                                  ({cmd_i[7], cmd_i[2:0]} != cpu_pkg::REG_PC);
                end
            end
            // add imm8 * 4 to sp or pc, flags untouched
            6'b1010??: begin
                op_o       = cpu_pkg::ALU_ADD;
                rn_addr_o  = cmd_i[11] ? cpu_pkg::REG_SP : cpu_pkg::REG_PC;
                rd_addr_o  = {1'b0, cmd_i[10:8]};
                use_imm_o  = 1'b1;
                imm_o[9:2] = cmd_i[7:0];
                rd_we_o    = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/cpu_pkg.sv */
// widths, register numbers and operation encodings shared by the thumb datapath modules
`default_nettype none

package cpu_pkg;

    localparam int SYS_BITS      = 32;
    localparam int REG_ADDR_BITS = 4;
    localparam int NUM_REGS      = 16;

    // register numbers with a fixed role
    localparam logic [REG_ADDR_BITS-1:0] REG_SP = 4'd13;
    localparam logic [REG_ADDR_BITS-1:0] REG_PC = 4'd15;

    // any shift of 32 or more behaves as this amount
    localparam logic [5:0] SHIFT_SAT = 6'd33;

    // result source in execute, ALU_NONE marks a no-op slot
    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_SHIFT,
        ALU_ADD,
        ALU_MUL,
        ALU_BITWISE
    } alu_op_e;

    // order follows the immediate shift opcode bits 12:11
    typedef enum logic [1:0] {
        SH_LSL,
        SH_LSR,
        SH_ASR,
        SH_ROR
    } shift_kind_e;

    // BIC is AND with m inverted
    typedef enum logic [1:0] {
        BW_AND,
        BW_ORR,
        BW_XOR
    } bitwise_kind_e;

    // adder carry-in
    typedef enum logic [1:0] {
        CIN_ZERO,
        CIN_ONE,
        CIN_FLAG
    } cin_sel_e;

    // flag positions in the status word
    localparam int FLAG_N = 31;
    localparam int FLAG_Z = 30;
    localparam int FLAG_C = 29;
    localparam int FLAG_V = 28;

endpackage

`default_nettype wire
